/* Makefile */
VERILATOR ?= verilator
TOP       := tb_axil_to_mem_banked
RTL_TOP   := axil_to_mem_banked
FILELIST  := axil_to_mem_banked.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed
LINTFLAGS := --lint-only --timing
VFLAGS    := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

# RTL top alone, then the testbench around it
lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# Verdict comes from the log, not from the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* axil_to_mem_banked.f */
+incdir+design
design/mem_banked_pkg.sv
design/rd_port.sv
design/wr_port.sv
design/bank_xbar.sv
design/axil_to_mem_banked.sv
verif/tb_bank_model.sv
verif/tb_axil_to_mem_banked.sv

/* design/axil_to_mem_banked.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module axil_to_mem_banked (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Read address and data channels
  input  logic                                          ar_valid_i,
  input  logic                      [`MB_ADDR_WIDTH-1:0] ar_addr_i,
  output logic                                          ar_ready_o,
  output logic                                          r_valid_o,
  output mem_banked_pkg::mem_data_t                     r_data_o,
  input  logic                                          r_ready_i,
  // Write request and response channels
  input  logic                                          wr_valid_i,
  input  mem_banked_pkg::wr_req_t                       wr_req_i,
  output logic                                          wr_ready_o,
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  // SRAM bank pins
  output logic                      [`MB_NUM_BANKS-1:0] mem_req_o,
  input  logic                      [`MB_NUM_BANKS-1:0] mem_gnt_i,
  output mem_banked_pkg::mem_addr_t [`MB_NUM_BANKS-1:0] mem_addr_o,
  output logic                      [`MB_NUM_BANKS-1:0] mem_we_o,
  output mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_wdata_o,
  output mem_banked_pkg::mem_strb_t [`MB_NUM_BANKS-1:0] mem_be_o,
  input  mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_rdata_i
);

  // Port to crossbar requests
  logic                      rd_breq_valid;
  mem_banked_pkg::bank_req_t rd_breq;
  logic                      rd_breq_ready;
  logic                      wr_breq_valid;
  mem_banked_pkg::bank_req_t wr_breq;
  logic                      wr_breq_ready;

  rd_port i_rd_port (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .ar_valid_i   ( ar_valid_i    ),
    .ar_addr_i    ( ar_addr_i     ),
    .ar_ready_o   ( ar_ready_o    ),
    .r_valid_o    ( r_valid_o     ),
    .r_data_o     ( r_data_o      ),
    .r_ready_i    ( r_ready_i     ),
    .breq_valid_o ( rd_breq_valid ),
    .breq_o       ( rd_breq       ),
    .breq_ready_i ( rd_breq_ready ),
    .mem_rdata_i  ( mem_rdata_i   )
  );

  wr_port i_wr_port (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .wr_valid_i   ( wr_valid_i    ),
    .wr_req_i     ( wr_req_i      ),
    .wr_ready_o   ( wr_ready_o    ),
    .b_valid_o    ( b_valid_o     ),
    .b_ready_i    ( b_ready_i     ),
    .breq_valid_o ( wr_breq_valid ),
    .breq_o       ( wr_breq       ),
    .breq_ready_i ( wr_breq_ready )
  );

  // Arbitrates both ports onto the banks
  bank_xbar i_bank_xbar (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .rd_valid_i  ( rd_breq_valid ),
    .rd_req_i    ( rd_breq       ),
    .rd_ready_o  ( rd_breq_ready ),
    .wr_valid_i  ( wr_breq_valid ),
    .wr_req_i    ( wr_breq       ),
    .wr_ready_o  ( wr_breq_ready ),
    .mem_req_o   ( mem_req_o     ),
    .mem_gnt_i   ( mem_gnt_i     ),
    .mem_addr_o  ( mem_addr_o    ),
    .mem_we_o    ( mem_we_o      ),
    .mem_wdata_o ( mem_wdata_o   ),
    .mem_be_o    ( mem_be_o      )
  );

endmodule

/* design/bank_xbar.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module bank_xbar (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Read port request
  input  logic                                          rd_valid_i,
  input  mem_banked_pkg::bank_req_t                     rd_req_i,
  output logic                                          rd_ready_o,
  // Write port request
  input  logic                                          wr_valid_i,
  input  mem_banked_pkg::bank_req_t                     wr_req_i,
  output logic                                          wr_ready_o,
  // Bank pins
  output logic                      [`MB_NUM_BANKS-1:0] mem_req_o,
  input  logic                      [`MB_NUM_BANKS-1:0] mem_gnt_i,
  output mem_banked_pkg::mem_addr_t [`MB_NUM_BANKS-1:0] mem_addr_o,
  output logic                      [`MB_NUM_BANKS-1:0] mem_we_o,
  output mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_wdata_o,
  output mem_banked_pkg::mem_strb_t [`MB_NUM_BANKS-1:0] mem_be_o
);

  // Per bank state, choice 0 is the read port and 1 the write port
  logic [`MB_NUM_BANKS-1:0] rd_hit;
  logic [`MB_NUM_BANKS-1:0] wr_hit;
  logic [`MB_NUM_BANKS-1:0] choice;
  logic [`MB_NUM_BANKS-1:0] rd_gnt;
  logic [`MB_NUM_BANKS-1:0] wr_gnt;
  logic [`MB_NUM_BANKS-1:0] lock_q;
  logic [`MB_NUM_BANKS-1:0] lock_sel_q;
  logic [`MB_NUM_BANKS-1:0] rr_q;

  mem_banked_pkg::bank_req_t [`MB_NUM_BANKS-1:0] bank_req;

  for (genvar b = 0; b < `MB_NUM_BANKS; b++) begin : gen_bank
    // Port requests aimed at this bank
    assign rd_hit[b] = rd_valid_i & (rd_req_i.sel == mem_banked_pkg::bank_sel_t'(b));
    assign wr_hit[b] = wr_valid_i & (wr_req_i.sel == mem_banked_pkg::bank_sel_t'(b));

    // Locked choice wins, else round robin on conflict, else whoever asks
    always_comb begin
      if (lock_q[b]) begin
        choice[b] = lock_sel_q[b];
      end else if (rd_hit[b] && wr_hit[b]) begin
        choice[b] = rr_q[b];
      end else begin
        choice[b] = wr_hit[b];
      end
    end

    assign mem_req_o[b] = rd_hit[b] | wr_hit[b];
    assign bank_req[b]  = choice[b] ? wr_req_i : rd_req_i;

    // Grant goes back to the chosen port only
    assign rd_gnt[b] = mem_req_o[b] & mem_gnt_i[b] & ~choice[b];
    assign wr_gnt[b] = mem_req_o[b] & mem_gnt_i[b] & choice[b];

    // Drive the bank pins from the selected payload
    assign mem_addr_o[b]  = bank_req[b].addr;
    assign mem_we_o[b]    = bank_req[b].we;
    assign mem_wdata_o[b] = bank_req[b].wdata;
    assign mem_be_o[b]    = bank_req[b].wstrb;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        lock_q[b]     <= 1'b0;
        lock_sel_q[b] <= 1'b0;
        rr_q[b]       <= 1'b0;
      end else begin
        // Hold the choice while the bank stalls
        lock_q[b]     <= mem_req_o[b] & ~mem_gnt_i[b];
        lock_sel_q[b] <= choice[b];
        // Next conflict favors the port that just lost
        if (mem_req_o[b] && mem_gnt_i[b] && rd_hit[b] && wr_hit[b]) begin
          rr_q[b] <= ~choice[b];
        end
      end
    end
  end

  // Each port targets one bank at a time
  assign rd_ready_o = |rd_gnt;
  assign wr_ready_o = |wr_gnt;

endmodule

/* design/mem_banked_defines.svh */
`ifndef MEM_BANKED_DEFINES_SVH
`define MEM_BANKED_DEFINES_SVH

// Bus side widths
`define MB_ADDR_WIDTH     32
`define MB_DATA_WIDTH     32

// Bank organization
`define MB_NUM_BANKS      4
`define MB_BANK_SEL_WIDTH 2
`define MB_BYTE_OFS_WIDTH 2
`define MB_MEM_ADDR_WIDTH 11

// Cycles from bank grant to read data on mem_rdata_i
`define MB_MEM_LATENCY    2

// Read response buffering, also the read outstanding limit
`define MB_RD_FIFO_DEPTH  4

`endif

/* design/mem_banked_pkg.sv */
`include "mem_banked_defines.svh"

package mem_banked_pkg;

  // Basic word level types
  typedef logic [`MB_DATA_WIDTH-1:0]     mem_data_t;
  typedef logic [`MB_DATA_WIDTH/8-1:0]   mem_strb_t;
  typedef logic [`MB_BANK_SEL_WIDTH-1:0] bank_sel_t;
  typedef logic [`MB_MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // Field view of a bus byte address
  typedef struct packed {
    logic [`MB_ADDR_WIDTH-`MB_MEM_ADDR_WIDTH-`MB_BANK_SEL_WIDTH-`MB_BYTE_OFS_WIDTH-1:0] unused;
    mem_addr_t                         word;
    bank_sel_t                         bank;
    logic [`MB_BYTE_OFS_WIDTH-1:0]     ofs;
  } addr_fields_t;

  // Same address word, flat or split into bank and word fields
  typedef union packed {
    logic [`MB_ADDR_WIDTH-1:0] raw;
    addr_fields_t              f;
  } addr_decode_u;

  // Merged AW and W beat from the bus
  typedef struct packed {
    logic [`MB_ADDR_WIDTH-1:0] addr;
    mem_data_t                 wdata;
    mem_strb_t                 wstrb;
  } wr_req_t;

  // Payload carried through the crossbar to one bank
  typedef struct packed {
    bank_sel_t sel;
    mem_addr_t addr;
    logic      we;
    mem_data_t wdata;
    mem_strb_t wstrb;
  } bank_req_t;

  // One entry of the read routing shift register
  typedef struct packed {
    bank_sel_t sel;
    logic      valid;
  } rd_route_t;

endpackage

/* design/rd_port.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module rd_port (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Read address channel
  input  logic                                          ar_valid_i,
  input  logic [`MB_ADDR_WIDTH-1:0]                     ar_addr_i,
  output logic                                          ar_ready_o,
  // Read data channel
  output logic                                          r_valid_o,
  output mem_banked_pkg::mem_data_t                     r_data_o,
  input  logic                                          r_ready_i,
  // Request towards the crossbar
  output logic                                          breq_valid_o,
  output mem_banked_pkg::bank_req_t                     breq_o,
  input  logic                                          breq_ready_i,
  // Read data from all banks
  input  mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_rdata_i
);

  localparam int unsigned PTR_W = $clog2(`MB_RD_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`MB_RD_FIFO_DEPTH + 1);
  localparam int unsigned LAST  = `MB_MEM_LATENCY - 1;

  mem_banked_pkg::addr_decode_u                          ar_dec;
  mem_banked_pkg::bank_req_t                             req_q;
  logic                                                  req_valid_q;
  logic [CNT_W-1:0]                                      out_cnt_q;
  mem_banked_pkg::rd_route_t                             route_in;
  mem_banked_pkg::rd_route_t [`MB_MEM_LATENCY-1:0]       route_q;
  mem_banked_pkg::mem_data_t                             fifo_mem [`MB_RD_FIFO_DEPTH];
  logic [PTR_W:0]                                        wr_ptr_q;
  logic [PTR_W:0]                                        rd_ptr_q;
  logic                                                  ar_fire;
  logic                                                  r_fire;
  logic                                                  push;

  // Split the byte address into bank and word fields
  assign ar_dec.raw = ar_addr_i;

  // Only one request held, and no more reads than FIFO slots
  assign ar_ready_o = ~req_valid_q & (out_cnt_q < CNT_W'(`MB_RD_FIFO_DEPTH));
  assign ar_fire    = ar_valid_i & ar_ready_o;
  assign r_fire     = r_valid_o & r_ready_i;

  assign breq_valid_o = req_valid_q;
  assign breq_o       = req_q;

  // Request register, cleared once the crossbar takes it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
    end else if (ar_fire) begin
      req_valid_q <= 1'b1;
    end else if (breq_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // Payload, read only so write fields stay zero
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      req_q <= mem_banked_pkg::bank_req_t'{
        sel:   ar_dec.f.bank,
        addr:  ar_dec.f.word,
        we:    1'b0,
        wdata: '0,
        wstrb: '0
      };
    end
  end

  // Outstanding reads from acceptance until popped off the R channel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_cnt_q <= '0;
    end else if (ar_fire && !r_fire) begin
      out_cnt_q <= out_cnt_q + 1'b1;
    end else if (r_fire && !ar_fire) begin
      out_cnt_q <= out_cnt_q - 1'b1;
    end
  end

  // Remember which bank was granted, entry valid on the access edge
  assign route_in = mem_banked_pkg::rd_route_t'{
    sel:   req_q.sel,
    valid: req_valid_q & breq_ready_i
  };

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      route_q <= '0;
    end else begin
      route_q[0] <= route_in;
      for (int i = 1; i < `MB_MEM_LATENCY; i++) begin
        route_q[i] <= route_q[i-1];
      end
    end
  end

  // Far end of the shift register lines up with the bank read data
  assign push = route_q[LAST].valid;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q[PTR_W-1:0]] <= mem_rdata_i[route_q[LAST].sel];
    end
  end

  // Pointers carry a wrap bit, equal means empty
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (r_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign r_valid_o = (wr_ptr_q != rd_ptr_q);
  assign r_data_o  = fifo_mem[rd_ptr_q[PTR_W-1:0]];

endmodule

/* design/wr_port.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module wr_port (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Merged write request channel
  input  logic                      wr_valid_i,
  input  mem_banked_pkg::wr_req_t   wr_req_i,
  output logic                      wr_ready_o,
  // Write response channel
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  // Request towards the crossbar
  output logic                      breq_valid_o,
  output mem_banked_pkg::bank_req_t breq_o,
  input  logic                      breq_ready_i
);

  mem_banked_pkg::addr_decode_u wr_dec;
  mem_banked_pkg::bank_req_t    req_q;
  logic                         req_valid_q;
  logic                         b_valid_q;
  logic                         wr_fire;

  assign wr_dec.raw = wr_req_i.addr;

  // One write in flight, blocked until B is taken
  assign wr_ready_o = ~req_valid_q & ~b_valid_q;
  assign wr_fire    = wr_valid_i & wr_ready_o;

  assign breq_valid_o = req_valid_q;
  assign breq_o       = req_q;
  assign b_valid_o    = b_valid_q;

  // Bank write request held until the crossbar accepts
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
      b_valid_q   <= 1'b0;
    end else begin
      if (wr_fire) begin
        req_valid_q <= 1'b1;
      end else if (breq_ready_i) begin
        req_valid_q <= 1'b0;
      end
      // Response raised the cycle after the bank access
      if (req_valid_q && breq_ready_i) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      req_q <= mem_banked_pkg::bank_req_t'{
        sel:   wr_dec.f.bank,
        addr:  wr_dec.f.word,
        we:    1'b1,
        wdata: wr_req_i.wdata,
        wstrb: wr_req_i.wstrb
      };
    end
  end

endmodule

/* verif/tb_axil_to_mem_banked.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module tb_axil_to_mem_banked;

  localparam int unsigned MAX_CYCLES = 20000;
  localparam int unsigned WORDS      = 1 << `MB_MEM_ADDR_WIDTH;
  localparam int unsigned NB         = `MB_NUM_BANKS;
  localparam int unsigned HI_W       = `MB_ADDR_WIDTH - `MB_MEM_ADDR_WIDTH
                                       - `MB_BANK_SEL_WIDTH - `MB_BYTE_OFS_WIDTH;

  logic                                clk_i;
  logic                                rst_i;
  logic                                ar_valid_i;
  logic [`MB_ADDR_WIDTH-1:0]           ar_addr_i;
  logic                                ar_ready_o;
  logic                                r_valid_o;
  mem_banked_pkg::mem_data_t           r_data_o;
  logic                                r_ready_i;
  logic                                wr_valid_i;
  mem_banked_pkg::wr_req_t             wr_req_i;
  logic                                wr_ready_o;
  logic                                b_valid_o;
  logic                                b_ready_i;
  logic                      [NB-1:0]  mem_req_o;
  logic                      [NB-1:0]  mem_gnt_i;
  mem_banked_pkg::mem_addr_t [NB-1:0]  mem_addr_o;
  logic                      [NB-1:0]  mem_we_o;
  mem_banked_pkg::mem_data_t [NB-1:0]  mem_wdata_o;
  mem_banked_pkg::mem_strb_t [NB-1:0]  mem_be_o;
  mem_banked_pkg::mem_data_t [NB-1:0]  mem_rdata_i;

  logic [NB-1:0]             stall_mask;
  logic                      stall_all;
  logic                      stall_rand;
  logic [31:0]               lfsr_q;
  int unsigned               cycle_cnt;
  // Expected memory contents per bank and word
  mem_banked_pkg::mem_data_t ref_mem [NB][WORDS];

  axil_to_mem_banked dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .ar_valid_i  ( ar_valid_i  ),
    .ar_addr_i   ( ar_addr_i   ),
    .ar_ready_o  ( ar_ready_o  ),
    .r_valid_o   ( r_valid_o   ),
    .r_data_o    ( r_data_o    ),
    .r_ready_i   ( r_ready_i   ),
    .wr_valid_i  ( wr_valid_i  ),
    .wr_req_i    ( wr_req_i    ),
    .wr_ready_o  ( wr_ready_o  ),
    .b_valid_o   ( b_valid_o   ),
    .b_ready_i   ( b_ready_i   ),
    .mem_req_o   ( mem_req_o   ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_we_o    ( mem_we_o    ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_be_o    ( mem_be_o    ),
    .mem_rdata_i ( mem_rdata_i )
  );

  tb_bank_model bank_model (
    .clk_i       ( clk_i       ),
    .stall_i     ( stall_mask  ),
    .mem_req_i   ( mem_req_o   ),
    .mem_gnt_o   ( mem_gnt_i   ),
    .mem_addr_i  ( mem_addr_o  ),
    .mem_we_i    ( mem_we_o    ),
    .mem_wdata_i ( mem_wdata_o ),
    .mem_be_i    ( mem_be_o    ),
    .mem_rdata_o ( mem_rdata_i )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Same start contents as the bank model
  function automatic mem_banked_pkg::mem_data_t fill_word(input int unsigned b,
                                                          input int unsigned w);
    return {~w[10:0], b[1:0], 6'h15, w[10:0], b[1:0]};
  endfunction

  function automatic logic [`MB_ADDR_WIDTH-1:0] make_addr(input mem_banked_pkg::bank_sel_t b,
                                                          input mem_banked_pkg::mem_addr_t w);
    return {{HI_W{1'b0}}, w, b, 2'b00};
  endfunction

  // Bank stalls change 1 ns after each edge
  always @(posedge clk_i) begin
    #1;
    for (int b = 0; b < NB; b++) begin
      if (stall_all) begin
        stall_mask[b] = 1'b1;
      end else if (stall_rand) begin
        stall_mask[b] = (rand_bits(2) == 32'd3);
      end else begin
        stall_mask[b] = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_data(input string name, input mem_banked_pkg::mem_data_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bank(input string name, input mem_banked_pkg::bank_sel_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input mem_banked_pkg::mem_addr_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Every task starts and ends 1 ns after a rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_read(input logic [`MB_ADDR_WIDTH-1:0] addr);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    @(negedge clk_i);
    while (!ar_ready_o) @(negedge clk_i);
    next_cycle();
    ar_valid_i = 1'b0;
  endtask

  task automatic recv_read(output mem_banked_pkg::mem_data_t data);
    r_ready_i = 1'b1;
    @(negedge clk_i);
    while (!r_valid_o) @(negedge clk_i);
    data = r_data_o;
    next_cycle();
    r_ready_i = 1'b0;
  endtask

  task automatic read_word(input mem_banked_pkg::bank_sel_t b, input mem_banked_pkg::mem_addr_t w);
    mem_banked_pkg::mem_data_t got;
    send_read(make_addr(b, w));
    recv_read(got);
    check_data("r_data_o", got, ref_mem[b][w]);
  endtask

  task automatic send_write(input mem_banked_pkg::bank_sel_t b, input mem_banked_pkg::mem_addr_t w,
                            input mem_banked_pkg::mem_data_t data,
                            input mem_banked_pkg::mem_strb_t strb);
    wr_valid_i = 1'b1;
    wr_req_i   = mem_banked_pkg::wr_req_t'{addr: make_addr(b, w), wdata: data, wstrb: strb};
    @(negedge clk_i);
    while (!wr_ready_o) @(negedge clk_i);
    next_cycle();
    wr_valid_i = 1'b0;
    // Only strobed bytes change
    for (int k = 0; k < `MB_DATA_WIDTH/8; k++) begin
      if (strb[k]) begin
        ref_mem[b][w][8*k +: 8] = data[8*k +: 8];
      end
    end
  endtask

  task automatic recv_b();
    b_ready_i = 1'b1;
    @(negedge clk_i);
    while (!b_valid_o) @(negedge clk_i);
    next_cycle();
    b_ready_i = 1'b0;
    // A duplicate response would still be up here
    check_flag("b_valid_o", b_valid_o, 1'b0);
  endtask

  task automatic write_word(input mem_banked_pkg::bank_sel_t b, input mem_banked_pkg::mem_addr_t w,
                            input mem_banked_pkg::mem_data_t data,
                            input mem_banked_pkg::mem_strb_t strb);
    send_write(b, w, data, strb);
    recv_b();
  endtask

  task automatic write_then_read();
    mem_banked_pkg::bank_sel_t b;
    mem_banked_pkg::mem_addr_t w;
    for (int i = 0; i < 8; i++) begin
      b = mem_banked_pkg::bank_sel_t'(rand_bits(2));
      w = mem_banked_pkg::mem_addr_t'(rand_bits(11));
      write_word(b, w, rand_bits(32), 4'hf);
      write_word(b, w, rand_bits(32), mem_banked_pkg::mem_strb_t'(rand_bits(4)));
      read_word(b, w);
    end
  endtask

  task automatic decode_address();
    logic [`MB_ADDR_WIDTH-1:0] addr;
    mem_banked_pkg::mem_data_t got;
    mem_banked_pkg::bank_sel_t seen;
    int                        hits;
    for (int i = 0; i < 8; i++) begin
      // Random upper and offset bits, bit 20 clear
      addr = rand_bits(32) & ~32'h0010_0000;
      stall_all = 1'b1;
      send_read(addr);
      @(negedge clk_i);
      hits = 0;
      seen = '0;
      for (int b = 0; b < NB; b++) begin
        if (mem_req_o[b]) begin
          hits++;
          seen = mem_banked_pkg::bank_sel_t'(b);
        end
      end
      if (hits != 1) begin
        abort_run($sformatf("Expected one bank request while stalled, saw %0d", hits));
      end
      check_bank("mem_req_o bank", seen, addr[3:2]);
      check_addr("mem_addr_o", mem_addr_o[seen], addr[14:4]);
      // A read must never drive a bank write
      check_flag("mem_we_o", mem_we_o[seen], 1'b0);
      next_cycle();
      stall_all = 1'b0;
      recv_read(got);
      check_data("r_data_o", got, ref_mem[addr[3:2]][addr[14:4]]);
      // Bit 20 lies above the decoded fields
      send_read(addr | 32'h0010_0000);
      recv_read(got);
      check_data("r_data_o alias", got, ref_mem[addr[3:2]][addr[14:4]]);
    end
  endtask

  // Writes stay in words 0x100 to 0x1ff, second half all on bank 2
  task automatic write_stream(input int n);
    mem_banked_pkg::bank_sel_t b;
    mem_banked_pkg::mem_addr_t w;
    for (int i = 0; i < n; i++) begin
      b = (i >= n/2) ? 2'd2 : mem_banked_pkg::bank_sel_t'(rand_bits(2));
      w = {3'b001, 8'(rand_bits(8))};
      write_word(b, w, rand_bits(32), mem_banked_pkg::mem_strb_t'(rand_bits(4)));
    end
  endtask

  // Reads stay in words 0x000 to 0x0ff
  task automatic read_stream(input int n);
    mem_banked_pkg::bank_sel_t b;
    mem_banked_pkg::mem_addr_t w;
    for (int i = 0; i < n; i++) begin
      b = (i >= n/2) ? 2'd2 : mem_banked_pkg::bank_sel_t'(rand_bits(2));
      w = {3'b000, 8'(rand_bits(8))};
      read_word(b, w);
    end
  endtask

  task automatic run_parallel(input int n);
    fork
      write_stream(n);
      read_stream(n);
    join
  endtask

  task automatic hold_read_data();
    mem_banked_pkg::mem_data_t exp_q [$];
    mem_banked_pkg::mem_data_t got;
    mem_banked_pkg::bank_sel_t b;
    mem_banked_pkg::mem_addr_t w;
    r_ready_i = 1'b0;
    for (int i = 0; i < `MB_RD_FIFO_DEPTH; i++) begin
      b = mem_banked_pkg::bank_sel_t'(rand_bits(2));
      w = mem_banked_pkg::mem_addr_t'(rand_bits(11));
      send_read(make_addr(b, w));
      exp_q.push_back(ref_mem[b][w]);
    end
    // One more read has to wait for a free slot
    b = mem_banked_pkg::bank_sel_t'(rand_bits(2));
    w = mem_banked_pkg::mem_addr_t'(rand_bits(11));
    ar_valid_i = 1'b1;
    ar_addr_i  = make_addr(b, w);
    exp_q.push_back(ref_mem[b][w]);
    repeat (12) begin
      @(negedge clk_i);
      check_flag("ar_ready_o", ar_ready_o, 1'b0);
    end
    next_cycle();
    fork
      send_read(make_addr(b, w));
      begin
        for (int i = 0; i < `MB_RD_FIFO_DEPTH + 1; i++) begin
          recv_read(got);
          check_data("r_data_o in order", got, exp_q.pop_front());
        end
      end
    join
  endtask

  task automatic hold_write_response();
    mem_banked_pkg::bank_sel_t b;
    mem_banked_pkg::mem_addr_t w;
    b = mem_banked_pkg::bank_sel_t'(rand_bits(2));
    w = mem_banked_pkg::mem_addr_t'(rand_bits(11));
    send_write(b, w, rand_bits(32), 4'hf);
    @(negedge clk_i);
    while (!b_valid_o) @(negedge clk_i);
    next_cycle();
    // Next write offered while B is held back
    wr_valid_i = 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      check_flag("wr_ready_o", wr_ready_o, 1'b0);
    end
    next_cycle();
    wr_valid_i = 1'b0;
    recv_b();
    write_word(b, w, rand_bits(32), 4'hf);
    read_word(b, w);
  endtask

  initial begin
    lfsr_q     = 32'h6e46;
    cycle_cnt  = 0;
    stall_all  = 1'b0;
    stall_rand = 1'b0;
    stall_mask = '0;
    rst_i      = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    wr_valid_i = 1'b0;
    wr_req_i   = '0;
    b_ready_i  = 1'b0;
    for (int unsigned b = 0; b < NB; b++) begin
      for (int unsigned w = 0; w < WORDS; w++) begin
        ref_mem[b][w] = fill_word(b, w);
      end
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Idle state right after reset
    @(negedge clk_i);
    check_flag("ar_ready_o", ar_ready_o, 1'b1);
    check_flag("wr_ready_o", wr_ready_o, 1'b1);
    check_flag("r_valid_o", r_valid_o, 1'b0);
    check_flag("b_valid_o", b_valid_o, 1'b0);
    next_cycle();
    write_then_read();
    decode_address();
    run_parallel(32);
    stall_rand = 1'b1;
    run_parallel(32);
    stall_rand = 1'b0;
    hold_read_data();
    stall_rand = 1'b1;
    hold_read_data();
    stall_rand = 1'b0;
    hold_write_response();
    $display("Verification passed");
    $finish;
  end

endmodule

/* verif/tb_bank_model.sv */
`timescale 1ns/1ps
`include "mem_banked_defines.svh"

module tb_bank_model (
  input  logic                                          clk_i,
  // High stalls the bank for this cycle
  input  logic                      [`MB_NUM_BANKS-1:0] stall_i,
  input  logic                      [`MB_NUM_BANKS-1:0] mem_req_i,
  output logic                      [`MB_NUM_BANKS-1:0] mem_gnt_o,
  input  mem_banked_pkg::mem_addr_t [`MB_NUM_BANKS-1:0] mem_addr_i,
  input  logic                      [`MB_NUM_BANKS-1:0] mem_we_i,
  input  mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_wdata_i,
  input  mem_banked_pkg::mem_strb_t [`MB_NUM_BANKS-1:0] mem_be_i,
  output mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] mem_rdata_o
);

  localparam int unsigned WORDS = 1 << `MB_MEM_ADDR_WIDTH;

  mem_banked_pkg::mem_data_t                     store [`MB_NUM_BANKS][WORDS];
  mem_banked_pkg::mem_data_t [`MB_NUM_BANKS-1:0] rd_pipe [`MB_MEM_LATENCY];

  // Start contents built from bank and word index together
  function automatic mem_banked_pkg::mem_data_t fill_word(input int unsigned b,
                                                          input int unsigned w);
    return {~w[10:0], b[1:0], 6'h15, w[10:0], b[1:0]};
  endfunction

  initial begin
    for (int unsigned b = 0; b < `MB_NUM_BANKS; b++) begin
      for (int unsigned w = 0; w < WORDS; w++) begin
        store[b][w] = fill_word(b, w);
      end
    end
  end

  // Grant whenever not stalled, even without a request
  assign mem_gnt_o = ~stall_i;

  always @(posedge clk_i) begin
    for (int b = 0; b < `MB_NUM_BANKS; b++) begin
      // Read every cycle, the port only takes data it routed
      rd_pipe[0][b] <= store[b][mem_addr_i[b]];
      if (mem_req_i[b] && mem_gnt_o[b] && mem_we_i[b]) begin
        for (int k = 0; k < `MB_DATA_WIDTH/8; k++) begin
          if (mem_be_i[b][k]) begin
            store[b][mem_addr_i[b]][8*k +: 8] <= mem_wdata_i[b][8*k +: 8];
          end
        end
      end
    end
    for (int i = 1; i < `MB_MEM_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // Data lines up MB_MEM_LATENCY edges after the access
  assign mem_rdata_o = rd_pipe[`MB_MEM_LATENCY-1];

endmodule
